//--- include/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// datapath and address width
`define RV_XLEN 32

// register file index width, 32 registers
`define RV_REG_AW 5

// byte strobes per data word
`define RV_STRB_W 4

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif

//--- logic/rv_pkg.sv
package rv_pkg;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		OP_LUI    = 7'b0110111,
		OP_JAL    = 7'b1101111,
		OP_BRANCH = 7'b1100011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_IMM    = 7'b0010011,
		OP_REG    = 7'b0110011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_PASS_B      // lui result
	} alu_op_e;

	// same order as funct3[1:0] of loads and stores
	typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} mem_size_e;

	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_sel_e;

	// operand source in execute
	typedef enum logic [1:0] {FWD_RF, FWD_MEM, FWD_WB} fwd_sel_e;

endpackage

//--- logic/rv_regfile.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_regfile (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  we,
	input  logic [`RV_REG_AW-1:0] waddr,
	input  logic [`RV_XLEN-1:0]   wdata,
	input  logic [`RV_REG_AW-1:0] raddr_a,
	input  logic [`RV_REG_AW-1:0] raddr_b,
	output logic [`RV_XLEN-1:0]   rdata_a,
	output logic [`RV_XLEN-1:0]   rdata_b
);
	logic [`RV_XLEN-1:0] regs [1:31];   // x0 has no storage

	always_ff @(posedge clk) begin
		if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// writeback bypass so decode sees this cycle's write
	assign rdata_a = (raddr_a == '0) ? '0 : (we && waddr == raddr_a) ? wdata : regs[raddr_a];
	assign rdata_b = (raddr_b == '0) ? '0 : (we && waddr == raddr_b) ? wdata : regs[raddr_b];

	// a write aimed at x0 leaves every register as it was
	property p_x0_write_ignored;
		@(posedge clk) disable iff (rst)
		(we && waddr == '0) ##1 (raddr_a == $past(raddr_a) && !(we && waddr == raddr_a))
			|-> rdata_a == $past(rdata_a);
	endproperty
	assert property (p_x0_write_ignored);

endmodule

//--- logic/rv_decoder.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_decoder (
	input  logic [`RV_XLEN-1:0]   instr,
	output logic [`RV_REG_AW-1:0] rs1,
	output logic [`RV_REG_AW-1:0] rs2,
	output logic [`RV_REG_AW-1:0] rd,
	output logic [`RV_XLEN-1:0]   imm,
	output rv_pkg::alu_op_e       alu_op,
	output logic                  alu_src_imm,
	output logic                  reg_write,
	output rv_pkg::wb_sel_e       wb_sel,
	output logic                  mem_read,
	output logic                  mem_write,
	output rv_pkg::mem_size_e     mem_size,
	output logic                  mem_unsigned,
	output logic                  branch,
	output logic                  branch_ne,
	output logic                  jump
);
	rv_pkg::opcode_e     opcode;
	rv_pkg::alu_op_e     arith_op;
	logic                arith_ok;
	logic [2:0]          funct3;
	logic                alt;     // funct7 bit 5, sub and sra
	logic [`RV_XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

	assign opcode = rv_pkg::opcode_e'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign alt    = instr[30];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	// funct3 to ALU op, shared by register and immediate forms
	always_comb begin
		arith_ok = 1'b1;
		arith_op = rv_pkg::ALU_ADD;
		case (funct3)
			3'b000: arith_op = (alt && opcode == rv_pkg::OP_REG) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
			3'b001: arith_op = rv_pkg::ALU_SLL;
			3'b010: arith_op = rv_pkg::ALU_SLT;
			3'b100: arith_op = rv_pkg::ALU_XOR;
			3'b101: arith_op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
			3'b110: arith_op = rv_pkg::ALU_OR;
			3'b111: arith_op = rv_pkg::ALU_AND;
			default: arith_ok = 1'b0;   // sltu not supported
		endcase
	end

	always_comb begin
		// bubble unless a supported encoding says otherwise
		rs1          = '0;
		rs2          = '0;
		rd           = instr[11:7];
		imm          = imm_i;
		alu_op       = rv_pkg::ALU_ADD;
		alu_src_imm  = 1'b0;
		reg_write    = 1'b0;
		wb_sel       = rv_pkg::WB_ALU;
		mem_read     = 1'b0;
		mem_write    = 1'b0;
		mem_size     = rv_pkg::MEM_WORD;
		mem_unsigned = 1'b0;
		branch       = 1'b0;
		branch_ne    = 1'b0;
		jump         = 1'b0;
		case (opcode)
			rv_pkg::OP_LUI: begin
				imm         = imm_u;
				alu_op      = rv_pkg::ALU_PASS_B;
				alu_src_imm = 1'b1;
				reg_write   = 1'b1;
			end
			rv_pkg::OP_JAL: begin
				imm       = imm_j;
				jump      = 1'b1;
				reg_write = 1'b1;
				wb_sel    = rv_pkg::WB_PC4;    // link value
			end
			rv_pkg::OP_BRANCH: begin
				if (funct3[2:1] == 2'b00) begin  // beq, bne only
					rs1       = instr[19:15];
					rs2       = instr[24:20];
					imm       = imm_b;
					branch    = 1'b1;
					branch_ne = funct3[0];
				end
			end
			rv_pkg::OP_LOAD: begin
				if (funct3[1:0] != 2'b11 && funct3[2:1] != 2'b11) begin
					rs1          = instr[19:15];
					alu_src_imm  = 1'b1;
					reg_write    = 1'b1;
					wb_sel       = rv_pkg::WB_MEM;
					mem_read     = 1'b1;
					mem_size     = rv_pkg::mem_size_e'(funct3[1:0]);
					mem_unsigned = funct3[2];
				end
			end
			rv_pkg::OP_STORE: begin
				if (!funct3[2] && funct3[1:0] != 2'b11) begin
					rs1         = instr[19:15];
					rs2         = instr[24:20];
					imm         = imm_s;
					alu_src_imm = 1'b1;
					mem_write   = 1'b1;
					mem_size    = rv_pkg::mem_size_e'(funct3[1:0]);
				end
			end
			rv_pkg::OP_IMM: begin
				if (arith_ok) begin
					rs1         = instr[19:15];
					alu_op      = arith_op;
					alu_src_imm = 1'b1;
					reg_write   = 1'b1;
				end
			end
			rv_pkg::OP_REG: begin
				if (arith_ok) begin
					rs1       = instr[19:15];
					rs2       = instr[24:20];
					alu_op    = arith_op;
					reg_write = 1'b1;
				end
			end
			default: ;
		endcase
	end

endmodule

//--- logic/rv_hazard.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_hazard (
	input  logic [`RV_REG_AW-1:0] id_rs1,
	input  logic [`RV_REG_AW-1:0] id_rs2,
	input  logic [`RV_REG_AW-1:0] ex_rs1,
	input  logic [`RV_REG_AW-1:0] ex_rs2,
	input  logic [`RV_REG_AW-1:0] ex_rd,
	input  logic                  ex_mem_read,
	input  logic [`RV_REG_AW-1:0] mem_rd,
	input  logic                  mem_reg_write,
	input  logic [`RV_REG_AW-1:0] wb_rd,
	input  logic                  wb_reg_write,
	output rv_pkg::fwd_sel_e      fwd_a,
	output rv_pkg::fwd_sel_e      fwd_b,
	output logic                  load_stall
);
	// youngest producer wins, x0 is never forwarded
	function automatic rv_pkg::fwd_sel_e pick_src(input logic [`RV_REG_AW-1:0] src);
		if (src == '0) begin
			return rv_pkg::FWD_RF;
		end
		if (mem_reg_write && mem_rd == src) begin
			return rv_pkg::FWD_MEM;
		end
		if (wb_reg_write && wb_rd == src) begin
			return rv_pkg::FWD_WB;
		end
		return rv_pkg::FWD_RF;
	endfunction

	assign fwd_a = pick_src(ex_rs1);
	assign fwd_b = pick_src(ex_rs2);

	// load result not ready until writeback
	assign load_stall = ex_mem_read && ex_rd != '0 && (ex_rd == id_rs1 || ex_rd == id_rs2);

endmodule

//--- logic/rv_execute.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_execute (
	input  logic [`RV_XLEN-1:0] pc,
	input  logic [`RV_XLEN-1:0] rs1_val,
	input  logic [`RV_XLEN-1:0] rs2_val,
	input  logic [`RV_XLEN-1:0] imm,
	input  rv_pkg::alu_op_e     alu_op,
	input  logic                alu_src_imm,
	input  logic                branch,
	input  logic                branch_ne,
	input  logic                jump,
	input  rv_pkg::fwd_sel_e    fwd_a,
	input  rv_pkg::fwd_sel_e    fwd_b,
	input  logic [`RV_XLEN-1:0] mem_fwd,
	input  logic [`RV_XLEN-1:0] wb_fwd,
	output logic [`RV_XLEN-1:0] alu_result,
	output logic [`RV_XLEN-1:0] store_data,
	output logic                redirect,
	output logic [`RV_XLEN-1:0] target
);
	logic [`RV_XLEN-1:0] op_a;
	logic [`RV_XLEN-1:0] op_b_reg;   // rs2 after forwarding
	logic [`RV_XLEN-1:0] op_b;
	logic [4:0]          shamt;

	function automatic logic [`RV_XLEN-1:0] fwd_mux(input rv_pkg::fwd_sel_e sel,
			input logic [`RV_XLEN-1:0] rf_val);
		case (sel)
			rv_pkg::FWD_MEM: return mem_fwd;
			rv_pkg::FWD_WB:  return wb_fwd;
			default:         return rf_val;
		endcase
	endfunction

	assign op_a       = fwd_mux(fwd_a, rs1_val);
	assign op_b_reg   = fwd_mux(fwd_b, rs2_val);
	assign op_b       = alu_src_imm ? imm : op_b_reg;
	assign shamt      = op_b[4:0];
	assign store_data = op_b_reg;

	always_comb begin
		case (alu_op)
			rv_pkg::ALU_SUB:    alu_result = op_a - op_b;
			rv_pkg::ALU_AND:    alu_result = op_a & op_b;
			rv_pkg::ALU_OR:     alu_result = op_a | op_b;
			rv_pkg::ALU_XOR:    alu_result = op_a ^ op_b;
			rv_pkg::ALU_SLT:    alu_result = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			rv_pkg::ALU_SLL:    alu_result = op_a << shamt;
			rv_pkg::ALU_SRL:    alu_result = op_a >> shamt;
			rv_pkg::ALU_SRA:    alu_result = $signed(op_a) >>> shamt;
			rv_pkg::ALU_PASS_B: alu_result = op_b;
			default:            alu_result = op_a + op_b;
		endcase
	end

	// branch and jal share one adder
	assign target   = pc + imm;
	assign redirect = jump || (branch && ((op_a == op_b_reg) != branch_ne));

endmodule

//--- logic/rv_mem_align.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_mem_align (
	input  logic [1:0]            addr_lo,
	input  rv_pkg::mem_size_e     mem_size,
	input  logic                  mem_unsigned,
	input  logic                  mem_write,
	input  logic [`RV_XLEN-1:0]   store_data,
	input  logic [`RV_XLEN-1:0]   rdata,
	output logic [`RV_STRB_W-1:0] web,
	output logic [`RV_XLEN-1:0]   wdata,
	output logic [`RV_XLEN-1:0]   load_value
);
	logic [4:0]          lane_shift;   // byte offset in bits
	logic [`RV_XLEN-1:0] lane_data;

	assign lane_shift = {addr_lo, 3'b000};
	assign lane_data  = rdata >> lane_shift;

	// store side, strobes are active low
	always_comb begin
		web   = '1;
		wdata = store_data;
		if (mem_write) begin
			case (mem_size)
				rv_pkg::MEM_BYTE: begin
					wdata = {24'b0, store_data[7:0]} << lane_shift;
					web   = ~(4'b0001 << addr_lo);
				end
				rv_pkg::MEM_HALF: begin
					if (addr_lo != 2'b11) begin   // crossing halfword is dropped
						wdata = {16'b0, store_data[15:0]} << lane_shift;
						web   = ~(4'b0011 << addr_lo);
					end
				end
				default: web = '0;
			endcase
		end
	end

	// load side
	always_comb begin
		case (mem_size)
			rv_pkg::MEM_BYTE: begin
				load_value = {{24{lane_data[7] & ~mem_unsigned}}, lane_data[7:0]};
			end
			rv_pkg::MEM_HALF: begin
				if (addr_lo == 2'b11) begin
					load_value = '0;
				end else begin
					load_value = {{16{lane_data[15] & ~mem_unsigned}}, lane_data[15:0]};
				end
			end
			default: load_value = rdata;
		endcase
	end

endmodule

//--- logic/rv_core.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_core (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [`RV_XLEN-1:0]   im_data,
	input  logic [`RV_XLEN-1:0]   dm_rdata,
	input  logic                  mem_ready,
	output logic [`RV_XLEN-1:0]   im_addr,
	output logic [`RV_XLEN-1:0]   dm_addr,
	output logic [`RV_XLEN-1:0]   dm_wdata,
	output logic [`RV_STRB_W-1:0] dm_web,
	output logic                  dm_oe
);
	logic freeze, load_stall, redirect;
	logic [`RV_XLEN-1:0] pc, target;

	// IF/ID
	logic                id_valid;
	logic [`RV_XLEN-1:0] id_pc, id_instr;
	logic [`RV_XLEN-1:0] rf_a, rf_b;
	logic [`RV_REG_AW-1:0] dec_rs1, dec_rs2, dec_rd;
	logic [`RV_XLEN-1:0] dec_imm;
	rv_pkg::alu_op_e     dec_alu_op;
	rv_pkg::wb_sel_e     dec_wb_sel;
	rv_pkg::mem_size_e   dec_mem_size;
	logic dec_alu_src_imm, dec_reg_write, dec_mem_read, dec_mem_write;
	logic dec_mem_unsigned, dec_branch, dec_branch_ne, dec_jump;

	// ID/EX
	logic                ex_valid;
	logic [`RV_XLEN-1:0] ex_pc, ex_rs1_val, ex_rs2_val, ex_imm;
	logic [`RV_REG_AW-1:0] ex_rs1, ex_rs2, ex_rd;
	rv_pkg::alu_op_e     ex_alu_op;
	rv_pkg::wb_sel_e     ex_wb_sel;
	rv_pkg::mem_size_e   ex_mem_size;
	logic ex_alu_src_imm, ex_reg_write, ex_mem_read, ex_mem_write;
	logic ex_mem_unsigned, ex_branch, ex_branch_ne, ex_jump;
	rv_pkg::fwd_sel_e    fwd_a, fwd_b;
	logic [`RV_XLEN-1:0] ex_alu, ex_store_data;

	// EX/MEM
	logic                mem_valid;
	logic [`RV_XLEN-1:0] mem_alu, mem_store_data, mem_pc4, mem_fwd, load_value;
	logic [`RV_REG_AW-1:0] mem_rd;
	rv_pkg::wb_sel_e     mem_wb_sel;
	rv_pkg::mem_size_e   mem_mem_size;
	logic mem_reg_write, mem_mem_read, mem_mem_write, mem_mem_unsigned;

	// MEM/WB
	logic                wb_valid;
	logic [`RV_XLEN-1:0] wb_alu, wb_load, wb_pc4, wb_data;
	logic [`RV_REG_AW-1:0] wb_rd;
	rv_pkg::wb_sel_e     wb_wb_sel;
	logic                wb_reg_write;

	assign freeze  = !mem_ready;   // whole pipe holds while data memory is busy
	assign im_addr = pc;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc <= `RV_RESET_PC;
		end else if (!freeze && !load_stall) begin
			pc <= redirect ? target : pc + 32'd4;
		end
	end

	// valid bits with priority freeze > stall > flush
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			id_valid  <= 1'b0;
			ex_valid  <= 1'b0;
			mem_valid <= 1'b0;
			wb_valid  <= 1'b0;
		end else if (!freeze) begin
			mem_valid <= ex_valid;
			wb_valid  <= mem_valid;
			if (load_stall) begin
				ex_valid <= 1'b0;          // bubble while IF/ID holds
			end else if (redirect) begin
				id_valid <= 1'b0;
				ex_valid <= 1'b0;
			end else begin
				id_valid <= 1'b1;
				ex_valid <= id_valid;
			end
		end
	end

	// pipeline payload qualified by the valid bits above
	always_ff @(posedge clk) begin
		if (!freeze) begin
			if (!load_stall) begin
				id_pc    <= pc;
				id_instr <= im_data;
			end
			ex_pc           <= id_pc;
			ex_rs1_val      <= rf_a;
			ex_rs2_val      <= rf_b;
			ex_imm          <= dec_imm;
			ex_rs1          <= dec_rs1;
			ex_rs2          <= dec_rs2;
			ex_rd           <= dec_rd;
			ex_alu_op       <= dec_alu_op;
			ex_alu_src_imm  <= dec_alu_src_imm;
			ex_reg_write    <= dec_reg_write;
			ex_wb_sel       <= dec_wb_sel;
			ex_mem_read     <= dec_mem_read;
			ex_mem_write    <= dec_mem_write;
			ex_mem_size     <= dec_mem_size;
			ex_mem_unsigned <= dec_mem_unsigned;
			ex_branch       <= dec_branch;
			ex_branch_ne    <= dec_branch_ne;
			ex_jump         <= dec_jump;

			mem_alu          <= ex_alu;
			mem_store_data   <= ex_store_data;
			mem_pc4          <= ex_pc + 32'd4;   // jal link
			mem_rd           <= ex_rd;
			mem_wb_sel       <= ex_wb_sel;
			mem_reg_write    <= ex_reg_write;
			mem_mem_read     <= ex_mem_read;
			mem_mem_write    <= ex_mem_write;
			mem_mem_size     <= ex_mem_size;
			mem_mem_unsigned <= ex_mem_unsigned;

			wb_alu       <= mem_alu;
			wb_load      <= load_value;
			wb_pc4       <= mem_pc4;
			wb_rd        <= mem_rd;
			wb_wb_sel    <= mem_wb_sel;
			wb_reg_write <= mem_reg_write;
		end
	end

	rv_regfile u_regfile (
		.clk     (clk),
		.rst     (rst),
		.we      (wb_valid && wb_reg_write && !freeze),
		.waddr   (wb_rd),
		.wdata   (wb_data),
		.raddr_a (dec_rs1),
		.raddr_b (dec_rs2),
		.rdata_a (rf_a),
		.rdata_b (rf_b)
	);

	rv_decoder u_decoder (
		.instr        (id_instr),
		.rs1          (dec_rs1),
		.rs2          (dec_rs2),
		.rd           (dec_rd),
		.imm          (dec_imm),
		.alu_op       (dec_alu_op),
		.alu_src_imm  (dec_alu_src_imm),
		.reg_write    (dec_reg_write),
		.wb_sel       (dec_wb_sel),
		.mem_read     (dec_mem_read),
		.mem_write    (dec_mem_write),
		.mem_size     (dec_mem_size),
		.mem_unsigned (dec_mem_unsigned),
		.branch       (dec_branch),
		.branch_ne    (dec_branch_ne),
		.jump         (dec_jump)
	);

	rv_hazard u_hazard (
		.id_rs1        (dec_rs1),
		.id_rs2        (dec_rs2),
		.ex_rs1        (ex_rs1),
		.ex_rs2        (ex_rs2),
		.ex_rd         (ex_rd),
		.ex_mem_read   (ex_valid && ex_mem_read),
		.mem_rd        (mem_rd),
		.mem_reg_write (mem_valid && mem_reg_write),
		.wb_rd         (wb_rd),
		.wb_reg_write  (wb_valid && wb_reg_write),
		.fwd_a         (fwd_a),
		.fwd_b         (fwd_b),
		.load_stall    (load_stall)
	);

	// loads never forward from MEM since the stall keeps them a stage apart
	assign mem_fwd = (mem_wb_sel == rv_pkg::WB_PC4) ? mem_pc4 : mem_alu;

	rv_execute u_execute (
		.pc          (ex_pc),
		.rs1_val     (ex_rs1_val),
		.rs2_val     (ex_rs2_val),
		.imm         (ex_imm),
		.alu_op      (ex_alu_op),
		.alu_src_imm (ex_alu_src_imm),
		.branch      (ex_valid && ex_branch),
		.branch_ne   (ex_branch_ne),
		.jump        (ex_valid && ex_jump),
		.fwd_a       (fwd_a),
		.fwd_b       (fwd_b),
		.mem_fwd     (mem_fwd),
		.wb_fwd      (wb_data),
		.alu_result  (ex_alu),
		.store_data  (ex_store_data),
		.redirect    (redirect),
		.target      (target)
	);

	rv_mem_align u_mem_align (
		.addr_lo      (mem_alu[1:0]),
		.mem_size     (mem_mem_size),
		.mem_unsigned (mem_mem_unsigned),
		.mem_write    (mem_valid && mem_mem_write),
		.store_data   (mem_store_data),
		.rdata        (dm_rdata),
		.web          (dm_web),
		.wdata        (dm_wdata),
		.load_value   (load_value)
	);

	assign dm_addr = mem_alu;
	assign dm_oe   = mem_valid && mem_mem_read;

	always_comb begin
		case (wb_wb_sel)
			rv_pkg::WB_MEM: wb_data = wb_load;
			rv_pkg::WB_PC4: wb_data = wb_pc4;
			default:        wb_data = wb_alu;
		endcase
	end

	// a load sitting in MEM never feeds the instruction in EX
	assert property (@(posedge clk) disable iff (rst)
		ex_valid && mem_valid && mem_mem_read
			|-> fwd_a != rv_pkg::FWD_MEM && fwd_b != rv_pkg::FWD_MEM);

	// data memory request holds while the RAM is not ready
	assert property (@(posedge clk) disable iff (rst)
		!mem_ready && mem_valid
			|=> $stable(dm_web) && $stable(dm_addr) && $stable(dm_wdata) && $stable(dm_oe));

endmodule

//--- verif/rv_tb_mem.sv
`timescale 1ns/1ps

module rv_tb_mem (
	input  logic        clk,
	input  logic        mem_ready,
	input  logic [31:0] im_addr,
	output logic [31:0] im_data,
	input  logic [31:0] dm_addr,
	input  logic [31:0] dm_wdata,
	input  logic [3:0]  dm_web,
	input  logic        dm_oe,
	output logic [31:0] dm_rdata
);
	logic [31:0] rom [0:63];    // loaded by the testbench
	logic [31:0] ram [0:255];   // 1 KiB of data

	// combinational reads on both sides
	assign im_data  = rom[im_addr[7:2]];
	assign dm_rdata = dm_oe ? ram[dm_addr[9:2]] : 32'h0;

	// background pattern, unique per byte address of each word
	initial begin
		for (int i = 0; i < 256; i++) begin
			ram[i] = 32'h5a5a_0000 ^ (32'(i) << 2);
		end
	end

	// store completes on an edge with mem_ready high
	always @(posedge clk) begin
		if (mem_ready && dm_web != 4'hf) begin
			for (int b = 0; b < 4; b++) begin
				if (!dm_web[b]) begin
					ram[dm_addr[9:2]][8*b +: 8] <= dm_wdata[8*b +: 8];
				end
			end
		end
	end

endmodule

//--- verif/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;
	localparam int PROG_LEN     = 61;
	localparam int DRAIN_CYCLES = 24;

	logic        clk;
	logic        rst;
	logic        mem_ready;
	logic [31:0] im_addr, im_data, dm_addr, dm_wdata, dm_rdata;
	logic [3:0]  dm_web;
	logic        dm_oe;

	logic [31:0] exp_addr[$];
	logic [31:0] exp_data[$];
	logic [3:0]  exp_web[$];
	string       exp_name[$];
	int          store_idx;
	int          prog_idx;
	logic [31:0] rng;
	logic        prev_busy;   // request held last cycle with mem_ready low
	logic [31:0] prev_addr, prev_wdata;
	logic [3:0]  prev_web;
	logic        prev_oe;

	rv_core UUT (
		.clk       (clk),
		.rst       (rst),
		.im_data   (im_data),
		.dm_rdata  (dm_rdata),
		.mem_ready (mem_ready),
		.im_addr   (im_addr),
		.dm_addr   (dm_addr),
		.dm_wdata  (dm_wdata),
		.dm_web    (dm_web),
		.dm_oe     (dm_oe)
	);

	rv_tb_mem u_mem (
		.clk       (clk),
		.mem_ready (mem_ready),
		.im_addr   (im_addr),
		.im_data   (im_data),
		.dm_addr   (dm_addr),
		.dm_wdata  (dm_wdata),
		.dm_web    (dm_web),
		.dm_oe     (dm_oe),
		.dm_rdata  (dm_rdata)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// instruction encoders following the ISA formats
	function automatic logic [31:0] enc_r(input int f7, input int f3, input int rd,
			input int rs1, input int rs2);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic logic [31:0] enc_i(input int opc, input int f3, input int rd,
			input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
	endfunction

	function automatic logic [31:0] enc_s(input int f3, input int rs2, input int rs1,
			input int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] enc_b(input int f3, input int rs1, input int rs2,
			input int imm);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
			7'b1100011};
	endfunction

	function automatic logic [31:0] enc_jal(input int rd, input int imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
	endfunction

	function automatic logic [31:0] enc_lui(input int rd, input int imm20);
		return {imm20[19:0], rd[4:0], 7'b0110111};
	endfunction

	task automatic emit(input logic [31:0] word);
		u_mem.rom[prog_idx] = word;
		prog_idx++;
	endtask

	task automatic expect_store(input string name, input logic [31:0] addr,
			input logic [31:0] data, input logic [3:0] web);
		exp_name.push_back(name);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
		exp_web.push_back(web);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] exp_v,
			input logic [31:0] act_v);
		$display("[ERROR] %s expected %08h actual %08h", name, exp_v, act_v);
		$display("Test failures found");
		$fatal(1, "value mismatch");
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Test failures found");
		$fatal(1, "check failed");
	endtask

	task automatic load_program();
		for (int i = 0; i < 64; i++) begin
			u_mem.rom[i] = 32'h0;   // decodes as a bubble
		end
		prog_idx = 0;
		// alu chain with back-to-back dependencies
		emit(enc_i(7'h13, 0, 1, 0, 5));
		emit(enc_i(7'h13, 0, 2, 0, -3));
		emit(enc_r(0, 0, 3, 1, 2));          // add
		emit(enc_r(7'h20, 0, 4, 3, 1));      // sub
		emit(enc_r(0, 4, 5, 4, 1));          // xor
		emit(enc_r(0, 6, 6, 5, 1));          // or
		emit(enc_r(0, 7, 7, 6, 1));          // and
		emit(enc_r(0, 2, 8, 4, 1));          // slt
		emit(enc_r(0, 1, 9, 1, 3));          // sll
		emit(enc_r(7'h20, 5, 11, 4, 3));     // sra
		emit(enc_r(0, 5, 12, 4, 3));         // srl
		emit(enc_lui(13, 20'h12345));
		emit(enc_i(7'h13, 0, 10, 0, 256));   // store base 0x100
		emit(enc_s(2, 3, 10, 0));
		emit(enc_s(2, 4, 10, 4));
		emit(enc_s(2, 5, 10, 8));
		emit(enc_s(2, 6, 10, 12));
		emit(enc_s(2, 7, 10, 16));
		emit(enc_s(2, 8, 10, 20));
		emit(enc_s(2, 9, 10, 24));
		emit(enc_s(2, 11, 10, 28));
		emit(enc_s(2, 12, 10, 32));
		emit(enc_s(2, 13, 10, 36));
		emit(enc_lui(15, 20'h80ff8));
		emit(enc_i(7'h13, 0, 15, 15, -255)); // x15 = 80ff7f01
		emit(enc_s(2, 15, 10, 40));
		// loads used right away
		emit(enc_i(7'h03, 0, 16, 10, 40));   // lb
		emit(enc_s(2, 16, 10, 44));
		emit(enc_i(7'h03, 0, 16, 10, 43));   // lb
		emit(enc_s(2, 16, 10, 48));
		emit(enc_i(7'h03, 4, 16, 10, 43));   // lbu
		emit(enc_s(2, 16, 10, 52));
		emit(enc_i(7'h03, 1, 16, 10, 42));   // lh
		emit(enc_s(2, 16, 10, 56));
		emit(enc_i(7'h03, 5, 16, 10, 42));   // lhu
		emit(enc_s(2, 16, 10, 60));
		emit(enc_i(7'h03, 1, 16, 10, 41));   // lh at an odd offset
		emit(enc_s(2, 16, 10, 64));
		emit(enc_i(7'h03, 2, 16, 10, 40));   // lw
		emit(enc_i(7'h13, 0, 17, 16, 1));
		emit(enc_s(2, 17, 10, 68));
		// byte and halfword stores
		emit(enc_s(0, 15, 10, 72));
		emit(enc_s(0, 15, 10, 73));
		emit(enc_s(0, 15, 10, 74));
		emit(enc_s(0, 15, 10, 75));
		emit(enc_s(1, 15, 10, 76));
		emit(enc_s(1, 15, 10, 77));
		emit(enc_s(1, 15, 10, 78));
		// each skipped store would show up as a mismatch
		emit(enc_b(0, 1, 1, 8));             // beq taken
		emit(enc_s(2, 1, 10, 200));
		emit(enc_s(2, 1, 10, 80));
		emit(enc_b(1, 1, 2, 8));             // bne taken
		emit(enc_s(2, 2, 10, 204));
		emit(enc_s(2, 3, 10, 84));
		emit(enc_b(0, 1, 2, 8));             // beq not taken
		emit(enc_s(2, 8, 10, 88));
		emit(enc_s(2, 9, 10, 92));
		emit(enc_jal(18, 8));                // at 0xe4
		emit(enc_s(2, 1, 10, 208));
		emit(enc_s(2, 18, 10, 96));
		emit(enc_jal(0, 0));                 // park here
	endtask

	task automatic load_expected();
		expect_store("alu_add", 32'h100, 32'h0000_0002, 4'h0);
		expect_store("alu_sub", 32'h104, 32'hffff_fffd, 4'h0);
		expect_store("alu_xor", 32'h108, 32'hffff_fff8, 4'h0);
		expect_store("alu_or", 32'h10c, 32'hffff_fffd, 4'h0);
		expect_store("alu_and", 32'h110, 32'h0000_0005, 4'h0);
		expect_store("alu_slt", 32'h114, 32'h0000_0001, 4'h0);
		expect_store("alu_sll", 32'h118, 32'h0000_0014, 4'h0);
		expect_store("alu_sra", 32'h11c, 32'hffff_ffff, 4'h0);
		expect_store("alu_srl", 32'h120, 32'h3fff_ffff, 4'h0);
		expect_store("alu_lui", 32'h124, 32'h1234_5000, 4'h0);
		expect_store("lui_addi", 32'h128, 32'h80ff_7f01, 4'h0);
		expect_store("load_lb0", 32'h12c, 32'h0000_0001, 4'h0);
		expect_store("load_lb3", 32'h130, 32'hffff_ff80, 4'h0);
		expect_store("load_lbu3", 32'h134, 32'h0000_0080, 4'h0);
		expect_store("load_lh2", 32'h138, 32'hffff_80ff, 4'h0);
		expect_store("load_lhu2", 32'h13c, 32'h0000_80ff, 4'h0);
		expect_store("load_lh1", 32'h140, 32'hffff_ff7f, 4'h0);
		expect_store("load_lw_use", 32'h144, 32'h80ff_7f02, 4'h0);
		expect_store("store_sb0", 32'h148, 32'h0000_0001, 4'he);
		expect_store("store_sb1", 32'h149, 32'h0000_0100, 4'hd);
		expect_store("store_sb2", 32'h14a, 32'h0001_0000, 4'hb);
		expect_store("store_sb3", 32'h14b, 32'h0100_0000, 4'h7);
		expect_store("store_sh0", 32'h14c, 32'h0000_7f01, 4'hc);
		expect_store("store_sh1", 32'h14d, 32'h007f_0100, 4'h9);
		expect_store("store_sh2", 32'h14e, 32'h7f01_0000, 4'h3);
		expect_store("branch_beq", 32'h150, 32'h0000_0005, 4'h0);
		expect_store("branch_bne", 32'h154, 32'h0000_0002, 4'h0);
		expect_store("branch_fall_a", 32'h158, 32'h0000_0001, 4'h0);
		expect_store("branch_fall_b", 32'h15c, 32'h0000_0014, 4'h0);
		expect_store("jal_link", 32'h160, 32'h0000_00e8, 4'h0);
	endtask

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		rst       = 1'b1;
		mem_ready = 1'b1;
		rng       = 32'h21d2_44e1;
		store_idx = 0;
		prev_busy = 1'b0;
		load_program();
		load_expected();
		repeat (16) @(posedge clk);
		#2 rst = 1'b0;
		while (store_idx < exp_addr.size()) begin
			@(posedge clk);
			#2;
			rng       = xorshift32(rng);
			mem_ready = (rng[1:0] != 2'b00);   // low about one cycle in four
		end
		// run on a while so a store past the list is still caught
		mem_ready = 1'b1;
		repeat (DRAIN_CYCLES) @(posedge clk);
		$display("All tests passed!");
		$finish;
	end

	// sampled mid-cycle since inputs only move just after the rising edge
	always @(negedge clk) begin
		if (rst) begin
			assert (dm_web == 4'hf) else report_failure("dm_web active during reset");
			assert (!dm_oe) else report_failure("dm_oe high during reset");
			assert (im_addr == 32'h0) else report_failure("fetch address not zero in reset");
		end else begin
			if (prev_busy) begin
				assert (dm_addr == prev_addr && dm_wdata == prev_wdata &&
					dm_web == prev_web && dm_oe == prev_oe)
				else report_failure("data memory outputs moved while mem_ready was low");
			end
			prev_busy  = !mem_ready && (dm_web != 4'hf || dm_oe);
			prev_addr  = dm_addr;
			prev_wdata = dm_wdata;
			prev_web   = dm_web;
			prev_oe    = dm_oe;
			if (mem_ready && dm_web != 4'hf) begin
				assert (store_idx < exp_addr.size())
				else report_failure("store seen after the last expected one");
				assert (dm_addr == exp_addr[store_idx])
				else report_mismatch({exp_name[store_idx], " addr"}, exp_addr[store_idx],
					dm_addr);
				assert (dm_web == exp_web[store_idx])
				else report_mismatch({exp_name[store_idx], " web"}, 32'(exp_web[store_idx]),
					32'(dm_web));
				assert (dm_wdata == exp_data[store_idx])
				else report_mismatch({exp_name[store_idx], " data"}, exp_data[store_idx],
					dm_wdata);
				store_idx++;
			end
		end
	end

	// two program passes at 40 cycles per instruction plus the drain
	initial begin
		repeat (16 + PROG_LEN * 40 * 2 + DRAIN_CYCLES) @(posedge clk);
		$display("Test failures found");
		$fatal(1, "timed out before all expected stores were seen");
	end

endmodule

//--- files.f
+incdir+include
logic/rv_pkg.sv
logic/rv_regfile.sv
logic/rv_decoder.sv
logic/rv_hazard.sv
logic/rv_execute.sv
logic/rv_mem_align.sv
logic/rv_core.sv
verif/rv_tb_mem.sv
verif/rv_core_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = rv_core_tb
FILELIST  = files.f
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check the log"
	@echo "  clean  remove build output and log"

obj_dir/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

test: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "All tests passed!" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
